// ==== dv/golden_trace.txt ====
# kind (0 write, 1 sleep, 2 halt), register index (hex), value (hex)
# trace events in program order, the halt record last
0 8 0040
0 9 0040
0 8 000a
0 a 000a
0 8 0014
0 1 0014
2 0 0000

// ==== sim.f ====
logic/reflet_pkg.sv
logic/flow_test_rom.sv
logic/fetch_unit.sv
logic/reg_file.sv
logic/exec_core.sv
logic/trace_out.sv
logic/reflet_top.sv
dv/reflet_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the reflet testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary -f sim.f --top-module reflet_tb -o reflet_sim \
  && ./obj_dir/reflet_sim > sim.log 2>&1
grep -q "All tests passed" sim.log \
  && echo "simulation PASS" \
  || { echo "simulation FAIL, see sim.log"; exit 1; }

// ==== dv/reflet_tb.sv ====
// testbench for the reflet processor, replays the golden trace of the flow-control program
`timescale 1ns/100ps

module reflet_tb;
  localparam int    half_period  = 50;
  localparam int    reset_cycles = 3;
  localparam int    quiet_cycles = 20;
  localparam int    passes       = 2; // second pass checks a rerun after reset
  localparam int    margin_lines = 4;
  localparam string golden_path  = "dv/golden_trace.txt";

  logic                          clk = 1'b0;
  logic                          reset;
  logic                          trace_valid;
  reflet_pkg::trace_t            trace;
  logic [reflet_pkg::word_w-1:0] retired;
  logic                          halted;

  reflet_pkg::trace_t golden_q[$];
  int                 watchdog_cycles = 0;

  reflet_top DUT (
    .clk         (clk),
    .reset       (reset),
    .trace_valid (trace_valid),
    .trace       (trace),
    .retired     (retired),
    .halted      (halted)
  );

  always #half_period clk = ~clk;

  task automatic stop_with_failure();
    $display("Some tests failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_trace(input reflet_pkg::trace_t expected,
                             input reflet_pkg::trace_t actual);
    if (actual.kind !== expected.kind) begin
      $display("Mismatch trace.kind: expected 0x%0h, got 0x%0h", expected.kind, actual.kind);
      stop_with_failure();
    end else if (actual.reg_index !== expected.reg_index) begin
      $display("Mismatch trace.reg_index: expected 0x%0h, got 0x%0h",
               expected.reg_index, actual.reg_index);
      stop_with_failure();
    end else if (actual.data !== expected.data) begin
      $display("Mismatch trace.data: expected 0x%04h, got 0x%04h", expected.data, actual.data);
      stop_with_failure();
    end
  endtask

  task automatic check_count(input logic [reflet_pkg::word_w-1:0] expected);
    if (retired !== expected) begin
      $display("Mismatch retired: expected 0x%04h, got 0x%04h", expected, retired);
      stop_with_failure();
    end
  endtask

  task automatic check_halted(input logic expected);
    if (halted !== expected) begin
      $display("Mismatch halted: expected 0x%0h, got 0x%0h", expected, halted);
      stop_with_failure();
    end
  endtask

  // one record per line: kind, register index, value, all hex
  task automatic load_golden();
    int                 fd;
    int                 fields;
    string              line;
    logic [31:0]        kind_val;
    logic [31:0]        index_val;
    logic [31:0]        data_val;
    reflet_pkg::trace_t entry;
    fd = $fopen(golden_path, "r");
    if (fd == 0) begin
      $display("cannot open the golden file %s", golden_path);
      stop_with_failure();
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() < 2 || line.getc(0) == "#") begin
          fields = 0; // blank or comment line
        end else begin
          fields = $sscanf(line, "%h %h %h", kind_val, index_val, data_val);
          if (fields != 3 || kind_val > 32'd2) begin
            $display("golden file holds a malformed line: %s", line);
            stop_with_failure();
          end else begin
            entry.kind      = reflet_pkg::trace_kind_e'(kind_val[1:0]);
            entry.reg_index = index_val[reflet_pkg::reg_idx_w-1:0];
            entry.data      = data_val[reflet_pkg::word_w-1:0];
            golden_q.push_back(entry);
          end
        end
      end
      $fclose(fd);
      if (golden_q.size() == 0 || golden_q[golden_q.size()-1].kind != reflet_pkg::tk_halt) begin
        $display("golden file is empty or does not end with a halt record");
        stop_with_failure();
      end
    end
  endtask

  // reset changes on the falling edge like every other input
  task automatic apply_reset();
    reset = 1'b1;
    repeat (reset_cycles) @(negedge clk);
    reset = 1'b0;
  endtask

  task automatic run_program(input int pass_no);
    int idx;
    idx = 0;
    apply_reset();
    check_halted(1'b0);
    check_count('0);
    while (idx < golden_q.size()) begin
      @(negedge clk); // outputs settle after the rising edge
      if (trace_valid) begin
        if (trace.kind == reflet_pkg::tk_sleep) begin
          $display("pass %0d saw a sleep event, the conditional jump was not taken", pass_no);
          stop_with_failure();
        end else begin
          check_trace(golden_q[idx], trace);
          idx++;
        end
      end else if (halted) begin
        $display("pass %0d halted after %0d of %0d events", pass_no, idx, golden_q.size());
        stop_with_failure();
      end
    end
    check_halted(1'b1);
    repeat (quiet_cycles) begin
      @(negedge clk);
      if (trace_valid) begin
        $display("pass %0d saw a trace event after the halt", pass_no);
        stop_with_failure();
      end
    end
    check_halted(1'b1);
    check_count(16'(golden_q.size()));
  endtask

  initial begin
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge clk);
    $display("watchdog expired after %0d cycles, the processor never halted", watchdog_cycles);
    stop_with_failure();
  end

  initial begin
    reset = 1'b1;
    load_golden();
    // per pass budget from the event count, plus reset and quiet time
    watchdog_cycles = passes * ((golden_q.size() + margin_lines) * 4 * 2
                                + reset_cycles + quiet_cycles);
    for (int p = 1; p <= passes; p++) begin
      run_program(p);
    end
    $display("All tests passed");
    $finish;
  end
endmodule

// ==== logic/reflet_top.sv ====
// reflet processor top, ROM plus fetch, core, registers and trace stage
`timescale 1ns/100ps

module reflet_top (
  input  logic                           clk,
  input  logic                           reset,
  output logic                           trace_valid,
  output reflet_pkg::trace_t             trace,
  output logic [reflet_pkg::word_w-1:0]  retired,
  output logic                           halted
);
  logic                              rom_enable;
  logic [reflet_pkg::addr_w-1:0]     rom_addr;
  logic [reflet_pkg::word_w-1:0]     rom_data;
  reflet_pkg::instr_t                instr;
  logic                              instr_valid;
  logic                              next_strobe;
  logic [reflet_pkg::addr_w-1:0]     next_pc;
  logic                              jump;
  logic [reflet_pkg::reg_idx_w-1:0]  read_index;
  logic [reflet_pkg::word_w-1:0]     read_data;
  logic                              write_en;
  logic [reflet_pkg::reg_idx_w-1:0]  write_index;
  logic [reflet_pkg::word_w-1:0]     write_data;
  logic                              event_valid;
  reflet_pkg::trace_t                event_data;

  flow_test_rom u_rom (
    .clk        (clk),
    .enable_out (rom_enable),
    .addr       (rom_addr),
    .data_out   (rom_data)
  );

  fetch_unit u_fetch (
    .clk         (clk),
    .reset       (reset),
    .rom_enable  (rom_enable),
    .rom_addr    (rom_addr),
    .rom_data    (rom_data),
    .instr       (instr),
    .instr_valid (instr_valid),
    .next_strobe (next_strobe),
    .next_pc     (next_pc),
    .jump        (jump)
  );

  exec_core u_core (
    .clk         (clk),
    .reset       (reset),
    .instr       (instr),
    .instr_valid (instr_valid),
    .next_strobe (next_strobe),
    .next_pc     (next_pc),
    .jump        (jump),
    .read_index  (read_index),
    .read_data   (read_data),
    .write_en    (write_en),
    .write_index (write_index),
    .write_data  (write_data),
    .event_valid (event_valid),
    .event_data  (event_data)
  );

  reg_file u_regs (
    .clk         (clk),
    .reset       (reset),
    .read_index  (read_index),
    .read_data   (read_data),
    .write_en    (write_en),
    .write_index (write_index),
    .write_data  (write_data)
  );

  trace_out u_trace (
    .clk         (clk),
    .reset       (reset),
    .event_valid (event_valid),
    .event_data  (event_data),
    .trace_valid (trace_valid),
    .trace       (trace),
    .retired     (retired),
    .halted      (halted)
  );
endmodule

// ==== logic/trace_out.sv ====
// trace output stage, registers events, counts them and latches halt
`timescale 1ns/100ps

module trace_out (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           event_valid,
  input  reflet_pkg::trace_t             event_data,
  output logic                           trace_valid,
  output reflet_pkg::trace_t             trace,
  output logic [reflet_pkg::word_w-1:0]  retired,
  output logic                           halted
);
  always_ff @(posedge clk) begin
    if (reset) begin
      trace_valid <= 1'b0;
      retired     <= '0;
      halted      <= 1'b0;
    end else begin
      trace_valid <= event_valid;
      if (event_valid) begin
        retired <= retired + 16'd1;
        if (event_data.kind == reflet_pkg::tk_halt) begin
          halted <= 1'b1; // held until reset
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (event_valid) begin
      trace <= event_data;
    end
  end
endmodule

// ==== logic/exec_core.sv ====
// execution core: decode, working register, compare flag, pc and return stack
`timescale 1ns/100ps

module exec_core (
  input  logic                              clk,
  input  logic                              reset,
  input  reflet_pkg::instr_t                instr,
  input  logic                              instr_valid,
  output logic                              next_strobe,
  output logic [reflet_pkg::addr_w-1:0]     next_pc,
  output logic                              jump,
  output logic [reflet_pkg::reg_idx_w-1:0]  read_index,
  input  logic [reflet_pkg::word_w-1:0]     read_data,
  output logic                              write_en,
  output logic [reflet_pkg::reg_idx_w-1:0]  write_index,
  output logic [reflet_pkg::word_w-1:0]     write_data,
  output logic                              event_valid,
  output reflet_pkg::trace_t                event_data
);
  logic [reflet_pkg::word_w-1:0]      wr, wr_next;
  logic                               flag, flag_next;
  logic [reflet_pkg::addr_w-1:0]      pc, pc_next, pc_seq;
  logic                               jump_next;
  logic [reflet_pkg::addr_w-1:0]      rs [reflet_pkg::stack_depth];
  logic [reflet_pkg::stack_ptr_w:0]   rs_depth;
  logic [reflet_pkg::stack_ptr_w-1:0] rs_top;
  logic                               push, pop;
  logic                               ev_valid_next;
  reflet_pkg::trace_t                 ev_next;
  logic                               sleep_next, stop_next;
  logic                               sleeping, stopped;
  logic                               accept;
  reflet_pkg::misc_e                  misc_code;

  assign accept      = instr_valid && !stopped;
  assign misc_code   = reflet_pkg::misc_e'(instr.arg);
  assign pc_seq      = pc + 8'd1;
  assign rs_top      = rs_depth[reflet_pkg::stack_ptr_w-1:0] - 1'b1; // last pushed entry
  assign read_index  = instr.arg;
  assign write_index = instr.arg;
  assign write_data  = wr;
  assign next_pc     = pc; // pc already points at the next instruction

  always_comb begin
    wr_next           = wr;
    flag_next         = flag;
    pc_next           = pc_seq;
    jump_next         = 1'b0;
    push              = 1'b0;
    pop               = 1'b0;
    write_en          = 1'b0;
    ev_valid_next     = 1'b0;
    sleep_next        = 1'b0;
    stop_next         = 1'b0;
    ev_next.kind      = reflet_pkg::tk_write;
    ev_next.reg_index = instr.arg;
    ev_next.data      = wr;
    if (accept) begin
      case (instr.op)
        reflet_pkg::op_set:  wr_next = {12'd0, instr.arg};
        reflet_pkg::op_setx: wr_next = {wr[11:0], instr.arg};
        reflet_pkg::op_read: wr_next = read_data;
        reflet_pkg::op_cpy: begin
          write_en      = 1'b1;
          ev_valid_next = 1'b1;
        end
        reflet_pkg::op_add:  wr_next = wr + read_data;
        reflet_pkg::op_sub:  wr_next = wr - read_data;
        reflet_pkg::op_eq: begin
          flag_next = (wr == read_data);
          wr_next   = {15'd0, wr == read_data};
        end
        reflet_pkg::op_misc: begin
          case (misc_code)
            reflet_pkg::misc_slp: begin
              sleep_next        = 1'b1;
              ev_valid_next     = 1'b1;
              ev_next.kind      = reflet_pkg::tk_sleep;
              ev_next.reg_index = '0;
              ev_next.data      = '0;
            end
            reflet_pkg::misc_jif: begin
              if (flag) begin
                pc_next   = wr[reflet_pkg::addr_w-1:0];
                jump_next = 1'b1;
              end
            end
            reflet_pkg::misc_call: begin
              push      = 1'b1;
              pc_next   = wr[reflet_pkg::addr_w-1:0];
              jump_next = 1'b1;
            end
            reflet_pkg::misc_ret: begin
              pop       = 1'b1;
              pc_next   = rs[rs_top];
              jump_next = 1'b1;
            end
            reflet_pkg::misc_quit: begin
              stop_next         = 1'b1;
              ev_valid_next     = 1'b1;
              ev_next.kind      = reflet_pkg::tk_halt;
              ev_next.reg_index = '0;
              ev_next.data      = '0;
            end
            default: ; // unused misc codes act as nop
          endcase
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr          <= '0;
      flag        <= 1'b0;
      pc          <= '0;
      jump        <= 1'b0;
      rs_depth    <= '0;
      next_strobe <= 1'b0;
      event_valid <= 1'b0;
      sleeping    <= 1'b0;
      stopped     <= 1'b0;
    end else begin
      next_strobe <= sleeping; // delayed release after slp
      sleeping    <= 1'b0;
      event_valid <= 1'b0;
      if (accept) begin
        wr          <= wr_next;
        flag        <= flag_next;
        pc          <= pc_next;
        jump        <= jump_next;
        event_valid <= ev_valid_next;
        sleeping    <= sleep_next;
        stopped     <= stop_next;
        next_strobe <= !(sleep_next || stop_next);
        if (push) begin
          rs_depth <= rs_depth + 1'b1;
        end else if (pop) begin
          rs_depth <= rs_depth - 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      rs[rs_depth[reflet_pkg::stack_ptr_w-1:0]] <= pc_seq; // return lands after the call
    end
    if (accept) begin
      event_data <= ev_next;
    end
  end
endmodule

// ==== logic/reg_file.sv ====
// general register file, one combinational read port and one write port
`timescale 1ns/100ps

module reg_file (
  input  logic                              clk,
  input  logic                              reset,
  input  logic [reflet_pkg::reg_idx_w-1:0]  read_index,
  output logic [reflet_pkg::word_w-1:0]     read_data,
  input  logic                              write_en,
  input  logic [reflet_pkg::reg_idx_w-1:0]  write_index,
  input  logic [reflet_pkg::word_w-1:0]     write_data
);
  logic [reflet_pkg::word_w-1:0] regs [reflet_pkg::reg_count];

  assign read_data = regs[read_index]; // no bypass, writes land before next read

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < reflet_pkg::reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (write_en) begin
      regs[write_index] <= write_data;
    end
  end
endmodule

// ==== logic/fetch_unit.sv ====
// instruction fetch, buffers one ROM word and issues its bytes one at a time
`timescale 1ns/100ps

module fetch_unit (
  input  logic                           clk,
  input  logic                           reset,
  output logic                           rom_enable,
  output logic [reflet_pkg::addr_w-1:0]  rom_addr,
  input  logic [reflet_pkg::word_w-1:0]  rom_data,
  output reflet_pkg::instr_t             instr,
  output logic                           instr_valid,
  input  logic                           next_strobe,
  input  logic [reflet_pkg::addr_w-1:0]  next_pc,
  input  logic                           jump
);
  reflet_pkg::fetch_state_e       state;
  logic [reflet_pkg::addr_w-1:0]  word_addr;
  logic [reflet_pkg::addr_w-1:0]  target_word;
  logic [reflet_pkg::word_w-1:0]  word_q;
  logic                           byte_sel;
  logic                           refetch;

  // odd byte after a sequential step is already buffered
  assign refetch     = next_strobe && (jump || !next_pc[0]);
  assign target_word = {next_pc[reflet_pkg::addr_w-1:1], 1'b0};

  // strobe cycle doubles as the request cycle, enable held through the wait
  assign rom_enable = (state != reflet_pkg::st_hold) || refetch;
  assign rom_addr   = refetch ? target_word : word_addr;

  assign instr = reflet_pkg::instr_t'(byte_sel ? word_q[15:8] : word_q[7:0]);

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= reflet_pkg::st_request;
      word_addr   <= '0;
      byte_sel    <= 1'b0;
      instr_valid <= 1'b0;
    end else begin
      instr_valid <= 1'b0;
      case (state)
        reflet_pkg::st_request: state <= reflet_pkg::st_wait;
        reflet_pkg::st_wait: begin
          state       <= reflet_pkg::st_hold;
          instr_valid <= 1'b1; // word lands this cycle
        end
        reflet_pkg::st_hold: begin
          if (next_strobe) begin
            byte_sel <= next_pc[0];
            if (refetch) begin
              word_addr <= target_word;
              state     <= reflet_pkg::st_wait;
            end else begin
              instr_valid <= 1'b1;
            end
          end
        end
        default: state <= reflet_pkg::st_request;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == reflet_pkg::st_wait) begin
      word_q <= rom_data;
    end
  end
endmodule

// ==== logic/flow_test_rom.sv ====
// flow-control test program ROM, two byte lanes forming a little-endian word
`timescale 1ns/100ps

module rom_byte_bank (
  input  logic                           clk,
  input  logic [reflet_pkg::addr_w-1:0]  addr,
  output logic [7:0]                     data
);
  always_ff @(posedge clk) begin
    case (addr)
      8'h00: data <= 8'h14; // set 4
      8'h01: data <= 8'h60; // setx 0, wr = 0x40
      8'h02: data <= 8'h38; // cpy R8
      8'h03: data <= 8'h39; // cpy R9
      8'h04: data <= 8'h1a; // set 10
      8'h05: data <= 8'h38; // cpy R8
      8'h06: data <= 8'h11; // set 1
      8'h07: data <= 8'h66; // setx 6, subroutine at 0x16
      8'h08: data <= 8'h0c; // call
      8'h09: data <= 8'h28; // read R8
      8'h0a: data <= 8'h31; // cpy R1
      8'h0b: data <= 8'h11; // set 1
      8'h0c: data <= 8'h64; // setx 4, wr = 20
      8'h0d: data <= 8'hc1; // eq R1
      8'h0e: data <= 8'h11; // set 1
      8'h0f: data <= 8'h65; // setx 5, nosleep at 0x15
      8'h10: data <= 8'h09; // jif
      8'h11: data <= 8'h00; // slp
      8'h12: data <= 8'h00; // slp
      8'h13: data <= 8'h00; // slp
      8'h14: data <= 8'h00; // slp
      8'h15: data <= 8'h0e; // nosleep: quit
      8'h16: data <= 8'h28; // subroutine: read R8
      8'h17: data <= 8'h3a; // cpy R10
      8'h18: data <= 8'h4a; // add R10
      8'h19: data <= 8'h38; // cpy R8
      8'h1a: data <= 8'h0d; // ret
      default: data <= 8'h00;
    endcase
  end
endmodule

module flow_test_rom (
  input  logic                           clk,
  input  logic                           enable_out,
  input  logic [reflet_pkg::addr_w-1:0]  addr,
  output logic [reflet_pkg::word_w-1:0]  data_out
);
  logic [reflet_pkg::addr_w-1:0] odd_addr;
  logic [7:0]                    data_even;
  logic [7:0]                    data_odd;

  assign odd_addr = addr + 8'd1;

  rom_byte_bank bank_even (
    .clk  (clk),
    .addr (addr),
    .data (data_even)
  );

  rom_byte_bank bank_odd (
    .clk  (clk),
    .addr (odd_addr),
    .data (data_odd)
  );

  assign data_out = enable_out ? {data_odd, data_even} : '0; // odd byte in high half
endmodule

// ==== logic/reflet_pkg.sv ====
// shared sizes, opcodes, state encodings and trace record for the reflet core
package reflet_pkg;

  localparam int word_w      = 16;
  localparam int addr_w      = 8;
  localparam int reg_count   = 16;
  localparam int reg_idx_w   = $clog2(reg_count);
  localparam int stack_depth = 4;
  localparam int stack_ptr_w = $clog2(stack_depth);

  // high nibble of an instruction byte
  typedef enum logic [3:0] {
    op_misc = 4'h0,
    op_set  = 4'h1,
    op_read = 4'h2,
    op_cpy  = 4'h3,
    op_add  = 4'h4,
    op_sub  = 4'h5,
    op_setx = 4'h6,
    op_eq   = 4'hc
  } opcode_e;

  // low nibble when op is op_misc
  typedef enum logic [3:0] {
    misc_slp  = 4'd0,
    misc_jif  = 4'd9,
    misc_call = 4'd12,
    misc_ret  = 4'd13,
    misc_quit = 4'd14
  } misc_e;

  typedef struct packed {
    opcode_e    op;
    logic [3:0] arg; // register, immediate or misc code
  } instr_t;

  typedef enum logic [1:0] {st_request, st_wait, st_hold} fetch_state_e;

  typedef enum logic [1:0] {tk_write, tk_sleep, tk_halt} trace_kind_e;

  typedef struct packed {
    trace_kind_e            kind;
    logic [reg_idx_w-1:0]   reg_index;
    logic [word_w-1:0]      data;
  } trace_t;

endpackage
